//--- sources.f
ooo_cfg_pkg.sv
ooo_uop_pkg.sv
ooo_rename.sv
ooo_issue_queue.sv
ooo_regfile.sv
ooo_alu.sv
ooo_rob.sv
ooo_core.sv
tb_ooo_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_ooo_core -o tb_ooo_core
./obj_dir/tb_ooo_core > sim.log
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

//--- tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

  import ooo_cfg_pkg::*;
  import ooo_uop_pkg::*;

  localparam int RESET_CYCLES    = 16;
  localparam int N_RANDOM        = 400;
  localparam int N_CHAINS        = 4;
  localparam int CHAIN_LEN       = 25;
  localparam int N_BURST         = 300;
  localparam int N_ZERO          = 30;
  localparam int N_UOPS          = N_RANDOM + N_CHAINS * CHAIN_LEN + N_BURST + N_ZERO;
  localparam int WATCHDOG_CYCLES = N_UOPS * 40 + 2000;

  logic    clk;
  logic    rst;
  logic    i_valid;
  uop_t    i_uop;
  logic    o_ready;
  commit_t o_commit;

  // In-order reference state
  data_t       model_regs [NUM_AREGS];
  commit_t     exp_q [$];
  commit_t     exp_commit;
  int          errors      = 0;
  int          n_accepted  = 0;
  int          n_committed = 0;

  ooo_core #(
    .ROB_DEPTH (16),
    .RS_DEPTH  (8)
  ) ooo_core_i (
    .clk      (clk),
    .rst      (rst),
    .i_valid  (i_valid),
    .i_uop    (i_uop),
    .o_ready  (o_ready),
    .o_commit (o_commit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==========================================================================
  // Reference model and compare tasks
  // ==========================================================================
  function automatic data_t alu_ref(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ADD:     alu_ref = a + b;
      SUB:     alu_ref = a - b;
      AND:     alu_ref = a & b;
      OR:      alu_ref = a | b;
      XOR:     alu_ref = a ^ b;
      SLL:     alu_ref = a << b[4:0];
      SRL:     alu_ref = a >> b[4:0];
      SLT:     alu_ref = data_t'($signed(a) < $signed(b));
      default: alu_ref = '0;
    endcase
  endfunction

  task automatic model_accept(input uop_t u);
    data_t   a;
    data_t   b;
    data_t   r;
    commit_t c;
    a = model_regs[u.rs1];
    b = u.use_imm ? u.imm : model_regs[u.rs2];
    r = (u.rd == '0) ? '0 : alu_ref(u.op, a, b);
    if (u.rd != '0) begin
      model_regs[u.rd] = r;
    end
    c.valid = 1'b1;
    c.rd    = u.rd;
    c.data  = r;
    exp_q.push_back(c);
    n_accepted++;
  endtask

  task automatic check_commit(input commit_t got, input commit_t exp);
    if (got.rd !== exp.rd) begin
      $display("ERR o_commit.rd got %h exp %h", got.rd, exp.rd);
      errors++;
    end
    if (got.data !== exp.data) begin
      $display("ERR o_commit.data got %h exp %h (rd %h)", got.data, exp.data, exp.rd);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  // ==========================================================================
  // Stimulus helpers
  // ==========================================================================
  function automatic uop_t rand_uop();
    uop_t u;
    u.rd      = areg_t'($urandom_range(0, 31));
    u.rs1     = areg_t'($urandom_range(0, 31));
    u.rs2     = areg_t'($urandom_range(0, 31));
    u.op      = alu_op_e'(3'($urandom_range(0, 7)));
    u.use_imm = 1'($urandom_range(0, 1));
    // Small immediates keep shift amounts and sums interesting
    if ($urandom_range(0, 1) == 1) begin
      u.imm = data_t'($urandom_range(0, 63));
    end else begin
      u.imm = data_t'($urandom());
    end
    return u;
  endfunction

  // Holds the micro-op on the input until the core takes it
  task automatic send_uop(input uop_t u);
    logic taken;
    taken = 1'b0;
    i_valid <= 1'b1;
    i_uop   <= u;
    while (!taken) begin
      @(negedge clk);
      taken = o_ready;
      if (taken) begin
        model_accept(u);
      end
      @(posedge clk);
    end
  endtask

  task automatic idle_cycles(input int n);
    i_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  // Commits are sampled mid-cycle
  always @(negedge clk) begin
    if (o_commit.valid === 1'b1) begin
      n_committed++;
      if (exp_q.size() == 0) begin
        $display("commit of rd %0d arrived with no outstanding micro-op", o_commit.rd);
        errors++;
      end else begin
        exp_commit = exp_q.pop_front();
        check_commit(o_commit, exp_commit);
      end
    end
  end

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    uop_t  u;
    areg_t prev;
    rst     <= 1'b1;
    i_valid <= 1'b0;
    i_uop   <= '0;
    void'($urandom(32'h2280_f53e));
    for (int r = 0; r < NUM_AREGS; r++) begin
      model_regs[r] = '0;
    end

    // Reset window plus one cycle after release
    for (int c = 0; c < RESET_CYCLES + 1; c++) begin
      @(posedge clk);
      if (c == RESET_CYCLES - 1) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check_bit("o_commit.valid", o_commit.valid, 1'b0);
      check_bit("o_ready", o_ready, 1'b1);
    end
    @(posedge clk);

    // Random micro-ops with idle gaps
    for (int i = 0; i < N_RANDOM; i++) begin
      send_uop(rand_uop());
      if ($urandom_range(0, 2) == 0) begin
        idle_cycles($urandom_range(1, 4));
      end
    end

    // Dependent chains where each op reads the previous rd
    // Odd chains leave one idle cycle so the next dispatch meets the producer's CDB
    for (int k = 0; k < N_CHAINS; k++) begin
      prev = areg_t'($urandom_range(1, 31));
      for (int j = 0; j < CHAIN_LEN; j++) begin
        u     = rand_uop();
        u.rs1 = prev;
        u.rs2 = prev;
        u.rd  = areg_t'($urandom_range(1, 31));
        send_uop(u);
        if (k % 2 == 1) begin
          idle_cycles(1);
        end
        prev = u.rd;
      end
      idle_cycles(2);
    end

    // Back-to-back burst over many destinations
    for (int i = 0; i < N_BURST; i++) begin
      u    = rand_uop();
      u.rd = areg_t'((i % 31) + 1);
      send_uop(u);
    end

    // Writes to x0 followed by reads of x0
    for (int i = 0; i < N_ZERO; i++) begin
      u = rand_uop();
      if (i % 2 == 0) begin
        u.rd      = '0;
        u.op      = ADD;
        u.use_imm = 1'b1;
        u.imm     = data_t'($urandom()) | data_t'(1);
      end else begin
        u.rd  = areg_t'($urandom_range(1, 31));
        u.rs1 = '0;
        u.rs2 = '0;
      end
      send_uop(u);
    end

    // Drain and look for stray commits
    idle_cycles(1);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);
    if (n_committed != n_accepted) begin
      $display("commit count %0d does not match accepted count %0d", n_committed, n_accepted);
      errors++;
    end

    $display("errors: %0d  accepted: %0d  committed: %0d", errors, n_accepted, n_committed);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog sized from the total micro-op count
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, %0d micro-ops still outstanding",
             WATCHDOG_CYCLES, exp_q.size());
    $display("errors: %0d  accepted: %0d  committed: %0d", errors, n_accepted, n_committed);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(
  parameter int ROB_DEPTH = 16,
  parameter int RS_DEPTH  = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_valid,
  input  ooo_uop_pkg::uop_t    i_uop,
  output logic                 o_ready,
  output ooo_uop_pkg::commit_t o_commit
);

  import ooo_cfg_pkg::*;
  import ooo_uop_pkg::*;

  logic     dispatch;
  renamed_t renamed;
  logic     rob_full;
  logic     iq_full;
  rob_tag_t tail_tag;
  logic     free_valid;
  preg_t    free_preg;
  logic     src1_ready;
  logic     src2_ready;
  issue_t   issue;
  data_t    rd_data1;
  data_t    rd_data2;
  cdb_t     cdb;

  // ==========================================================================
  // Input side
  // ==========================================================================
  ooo_rename rename_i (
    .clk          (clk),
    .rst          (rst),
    .i_valid      (i_valid),
    .i_uop        (i_uop),
    .i_rob_full   (rob_full),
    .i_iq_full    (iq_full),
    .i_tail_tag   (tail_tag),
    .i_free_valid (free_valid),
    .i_free_preg  (free_preg),
    .o_ready      (o_ready),
    .o_dispatch   (dispatch),
    .o_renamed    (renamed)
  );

  // ==========================================================================
  // Issue, operand read and execute
  // ==========================================================================
  ooo_issue_queue #(
    .RS_DEPTH (RS_DEPTH)
  ) issue_queue_i (
    .clk          (clk),
    .rst          (rst),
    .i_dispatch   (dispatch),
    .i_renamed    (renamed),
    .i_src1_ready (src1_ready),
    .i_src2_ready (src2_ready),
    .i_cdb        (cdb),
    .o_full       (iq_full),
    .o_issue      (issue)
  );

  ooo_regfile regfile_i (
    .clk          (clk),
    .rst          (rst),
    .i_dispatch   (dispatch),
    .i_renamed    (renamed),
    .i_rd_addr1   (issue.prs1),
    .i_rd_addr2   (issue.prs2),
    .i_cdb        (cdb),
    .o_src1_ready (src1_ready),
    .o_src2_ready (src2_ready),
    .o_rd_data1   (rd_data1),
    .o_rd_data2   (rd_data2)
  );

  ooo_alu alu_i (
    .clk     (clk),
    .rst     (rst),
    .i_issue (issue),
    .i_op1   (rd_data1),
    .i_op2   (rd_data2),
    .o_cdb   (cdb)
  );

  // ==========================================================================
  // Output side
  // ==========================================================================
  ooo_rob #(
    .ROB_DEPTH (ROB_DEPTH)
  ) rob_i (
    .clk          (clk),
    .rst          (rst),
    .i_dispatch   (dispatch),
    .i_renamed    (renamed),
    .i_cdb        (cdb),
    .o_full       (rob_full),
    .o_tail_tag   (tail_tag),
    .o_commit     (o_commit),
    .o_free_valid (free_valid),
    .o_free_preg  (free_preg)
  );

endmodule

//--- ooo_rob.sv
`timescale 1ns/1ps

module ooo_rob #(
  parameter int ROB_DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_dispatch,
  input  ooo_uop_pkg::renamed_t i_renamed,
  input  ooo_uop_pkg::cdb_t     i_cdb,
  output logic                  o_full,
  output ooo_cfg_pkg::rob_tag_t o_tail_tag,
  output ooo_uop_pkg::commit_t  o_commit,
  output logic                  o_free_valid,
  output ooo_cfg_pkg::preg_t    o_free_preg
);

  import ooo_cfg_pkg::*;

  localparam int CNT_W = $clog2(ROB_DEPTH + 1);

  areg_t                rob_rd      [ROB_DEPTH];
  preg_t                rob_old_prd [ROB_DEPTH];
  data_t                rob_data    [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] rob_done;
  rob_tag_t             head;
  rob_tag_t             tail;
  logic [CNT_W-1:0]     count;
  logic                 retire;

  function automatic rob_tag_t next_ptr(input rob_tag_t ptr);
    next_ptr = (ptr == rob_tag_t'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_full     = (count == CNT_W'(ROB_DEPTH));
  assign o_tail_tag = tail;
  assign retire     = (count != '0) && rob_done[head];

  // ==========================================================================
  // Pointers and completion
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      rob_done <= '0;
    end else begin
      if (i_dispatch) begin
        rob_done[tail] <= 1'b0;
        tail           <= next_ptr(tail);
      end
      if (i_cdb.valid) begin
        rob_done[i_cdb.tag] <= 1'b1;
      end
      if (retire) begin
        head <= next_ptr(head);
      end
      count <= count + CNT_W'(i_dispatch) - CNT_W'(retire);
    end
  end

  always_ff @(posedge clk) begin
    if (i_dispatch) begin
      rob_rd[tail]      <= i_renamed.rd;
      rob_old_prd[tail] <= i_renamed.old_prd;
    end
    if (i_cdb.valid) begin
      rob_data[i_cdb.tag] <= i_cdb.data;
    end
  end

  // ==========================================================================
  // Commit report and free strobe
  // ==========================================================================
  always_ff @(posedge clk) begin
    o_commit.rd   <= rob_rd[head];
    o_commit.data <= rob_data[head];
    o_free_preg   <= rob_old_prd[head];
    if (rst) begin
      o_commit.valid <= 1'b0;
      o_free_valid   <= 1'b0;
    end else begin
      o_commit.valid <= retire;
      o_free_valid   <= retire && (rob_old_prd[head] != '0);
    end
  end

endmodule

//--- ooo_alu.sv
`timescale 1ns/1ps

module ooo_alu (
  input  logic                clk,
  input  logic                rst,
  input  ooo_uop_pkg::issue_t i_issue,
  input  ooo_cfg_pkg::data_t  i_op1,
  input  ooo_cfg_pkg::data_t  i_op2,
  output ooo_uop_pkg::cdb_t   o_cdb
);

  import ooo_cfg_pkg::*;
  import ooo_uop_pkg::*;

  data_t op_b;
  data_t result;

  assign op_b = i_issue.use_imm ? i_issue.imm : i_op2;

  always_comb begin
    case (i_issue.op)
      ADD:     result = i_op1 + op_b;
      SUB:     result = i_op1 - op_b;
      AND:     result = i_op1 & op_b;
      OR:      result = i_op1 | op_b;
      XOR:     result = i_op1 ^ op_b;
      SLL:     result = i_op1 << op_b[4:0];
      SRL:     result = i_op1 >> op_b[4:0];
      SLT:     result = ($signed(i_op1) < $signed(op_b)) ? data_t'(1) : '0;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    o_cdb.tag  <= i_issue.tag;
    o_cdb.prd  <= i_issue.prd;
    // Results aimed at x0 go out as zero
    o_cdb.data <= (i_issue.prd == '0) ? '0 : result;
    if (rst) begin
      o_cdb.valid <= 1'b0;
    end else begin
      o_cdb.valid <= i_issue.valid;
    end
  end

endmodule

//--- ooo_regfile.sv
`timescale 1ns/1ps

module ooo_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_dispatch,
  input  ooo_uop_pkg::renamed_t i_renamed,
  input  ooo_cfg_pkg::preg_t    i_rd_addr1,
  input  ooo_cfg_pkg::preg_t    i_rd_addr2,
  input  ooo_uop_pkg::cdb_t     i_cdb,
  output logic                  o_src1_ready,
  output logic                  o_src2_ready,
  output ooo_cfg_pkg::data_t    o_rd_data1,
  output ooo_cfg_pkg::data_t    o_rd_data2
);

  import ooo_cfg_pkg::*;

  data_t                prf_data [NUM_PREGS];
  logic [NUM_PREGS-1:0] prf_ready;

  // Ready lookup for the dispatching micro-op, with the CDB write bypassed in
  assign o_src1_ready = prf_ready[i_renamed.prs1] ||
                        (i_cdb.valid && (i_cdb.prd == i_renamed.prs1));
  assign o_src2_ready = prf_ready[i_renamed.prs2] ||
                        (i_cdb.valid && (i_cdb.prd == i_renamed.prs2));

  assign o_rd_data1 = (i_rd_addr1 == '0) ? '0 : prf_data[i_rd_addr1];
  assign o_rd_data2 = (i_rd_addr2 == '0) ? '0 : prf_data[i_rd_addr2];

  // Register 0 is never marked busy and never written
  always_ff @(posedge clk) begin
    if (rst) begin
      prf_ready <= '1;
      for (int i = 0; i < NUM_PREGS; i++) begin
        prf_data[i] <= '0;
      end
    end else begin
      if (i_dispatch && (i_renamed.prd != '0)) begin
        prf_ready[i_renamed.prd] <= 1'b0;
      end
      if (i_cdb.valid && (i_cdb.prd != '0)) begin
        prf_ready[i_cdb.prd] <= 1'b1;
        prf_data[i_cdb.prd]  <= i_cdb.data;
      end
    end
  end

endmodule

//--- ooo_issue_queue.sv
`timescale 1ns/1ps

module ooo_issue_queue #(
  parameter int RS_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_dispatch,
  input  ooo_uop_pkg::renamed_t i_renamed,
  input  logic                  i_src1_ready,
  input  logic                  i_src2_ready,
  input  ooo_uop_pkg::cdb_t     i_cdb,
  output logic                  o_full,
  output ooo_uop_pkg::issue_t   o_issue
);

  import ooo_uop_pkg::*;

  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  renamed_t            slot_uop [RS_DEPTH];
  logic [RS_DEPTH-1:0] slot_valid;
  logic [RS_DEPTH-1:0] slot_rdy1;
  logic [RS_DEPTH-1:0] slot_rdy2;
  logic [RS_DEPTH-1:0] can_issue;
  logic                issue_hit;
  logic [IDX_W-1:0]    issue_idx;
  logic                free_hit;
  logic [IDX_W-1:0]    free_idx;

  assign can_issue = slot_valid & slot_rdy1 & slot_rdy2;
  assign o_full    = &slot_valid;

  // Scan from the top so the lowest index wins
  always_comb begin
    issue_hit = 1'b0;
    issue_idx = '0;
    free_hit  = 1'b0;
    free_idx  = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (can_issue[i]) begin
        issue_hit = 1'b1;
        issue_idx = IDX_W'(i);
      end
      if (!slot_valid[i]) begin
        free_hit = 1'b1;
        free_idx = IDX_W'(i);
      end
    end
  end

  always_comb begin
    o_issue.valid   = issue_hit;
    o_issue.prs1    = slot_uop[issue_idx].prs1;
    o_issue.prs2    = slot_uop[issue_idx].prs2;
    o_issue.prd     = slot_uop[issue_idx].prd;
    o_issue.tag     = slot_uop[issue_idx].tag;
    o_issue.op      = slot_uop[issue_idx].op;
    o_issue.use_imm = slot_uop[issue_idx].use_imm;
    o_issue.imm     = slot_uop[issue_idx].imm;
  end

  // ==========================================================================
  // Slot state: wakeup, issue and allocate
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_valid <= '0;
      slot_rdy1  <= '0;
      slot_rdy2  <= '0;
    end else begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (i_cdb.valid && slot_valid[i]) begin
          if (slot_uop[i].prs1 == i_cdb.prd) begin
            slot_rdy1[i] <= 1'b1;
          end
          if (slot_uop[i].prs2 == i_cdb.prd) begin
            slot_rdy2[i] <= 1'b1;
          end
        end
      end
      if (issue_hit) begin
        slot_valid[issue_idx] <= 1'b0;
      end
      if (i_dispatch && free_hit) begin
        slot_valid[free_idx] <= 1'b1;
        slot_rdy1[free_idx]  <= i_src1_ready;
        // An immediate operand never waits on rs2
        slot_rdy2[free_idx]  <= i_src2_ready || i_renamed.use_imm;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_dispatch && free_hit) begin
      slot_uop[free_idx] <= i_renamed;
    end
  end

endmodule

//--- ooo_rename.sv
`timescale 1ns/1ps

module ooo_rename (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_valid,
  input  ooo_uop_pkg::uop_t     i_uop,
  input  logic                  i_rob_full,
  input  logic                  i_iq_full,
  input  ooo_cfg_pkg::rob_tag_t i_tail_tag,
  input  logic                  i_free_valid,
  input  ooo_cfg_pkg::preg_t    i_free_preg,
  output logic                  o_ready,
  output logic                  o_dispatch,
  output ooo_uop_pkg::renamed_t o_renamed
);

  import ooo_cfg_pkg::*;

  localparam int FL_DEPTH = NUM_PREGS - NUM_AREGS;
  localparam int FL_PTR_W = $clog2(FL_DEPTH);
  localparam int FL_CNT_W = FL_PTR_W + 1;

  preg_t               rat    [NUM_AREGS];
  preg_t               fl_mem [FL_DEPTH];
  logic [FL_PTR_W-1:0] fl_head;
  logic [FL_PTR_W-1:0] fl_tail;
  logic [FL_CNT_W-1:0] fl_count;
  logic                alloc;

  // ==========================================================================
  // Accept decision
  // ==========================================================================
  assign o_ready    = (fl_count != '0) && !i_rob_full && !i_iq_full;
  assign o_dispatch = i_valid && o_ready;

  // x0 never takes a register from the free list
  assign alloc = o_dispatch && (i_uop.rd != '0);

  always_comb begin
    o_renamed.prs1    = rat[i_uop.rs1];
    o_renamed.prs2    = rat[i_uop.rs2];
    o_renamed.old_prd = rat[i_uop.rd];
    o_renamed.prd     = (i_uop.rd == '0) ? '0 : fl_mem[fl_head];
    o_renamed.rd      = i_uop.rd;
    o_renamed.tag     = i_tail_tag;
    o_renamed.op      = i_uop.op;
    o_renamed.use_imm = i_uop.use_imm;
    o_renamed.imm     = i_uop.imm;
  end

  // ==========================================================================
  // Alias table and free list
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_AREGS; i++) begin
        rat[i] <= preg_t'(i);
      end
      // Registers above the architectural ones start out free
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem[i] <= preg_t'(NUM_AREGS + i);
      end
      fl_head  <= '0;
      fl_tail  <= '0;
      fl_count <= FL_CNT_W'(FL_DEPTH);
    end else begin
      if (alloc) begin
        rat[i_uop.rd] <= fl_mem[fl_head];
        fl_head       <= fl_head + 1'b1;
      end
      // Old mappings come back from commit
      if (i_free_valid) begin
        fl_mem[fl_tail] <= i_free_preg;
        fl_tail         <= fl_tail + 1'b1;
      end
      fl_count <= fl_count + FL_CNT_W'(i_free_valid) - FL_CNT_W'(alloc);
    end
  end

endmodule

//--- ooo_uop_pkg.sv
package ooo_uop_pkg;

  import ooo_cfg_pkg::*;

  // Shifts take the low 5 bits of the second operand, SLT compares signed
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SLT
  } alu_op_e;

  // Decoded micro-op as it arrives at rename
  typedef struct packed {
    areg_t   rd;
    areg_t   rs1;
    areg_t   rs2;
    alu_op_e op;
    logic    use_imm;
    data_t   imm;
  } uop_t;

  // Micro-op after register renaming, tagged with its ROB slot
  typedef struct packed {
    preg_t    prd;
    preg_t    prs1;
    preg_t    prs2;
    preg_t    old_prd;
    areg_t    rd;
    rob_tag_t tag;
    alu_op_e  op;
    logic     use_imm;
    data_t    imm;
  } renamed_t;

  typedef struct packed {
    logic     valid;
    preg_t    prs1;
    preg_t    prs2;
    preg_t    prd;
    rob_tag_t tag;
    alu_op_e  op;
    logic     use_imm;
    data_t    imm;
  } issue_t;

  // Common data bus packet
  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    preg_t    prd;
    data_t    data;
  } cdb_t;

  typedef struct packed {
    logic  valid;
    areg_t rd;
    data_t data;
  } commit_t;

endpackage

//--- ooo_cfg_pkg.sv
package ooo_cfg_pkg;

  // ==========================================================================
  // Register counts and widths
  // ==========================================================================
  parameter int NUM_AREGS = 32;
  parameter int AREG_W    = 5;
  parameter int NUM_PREGS = 64;
  parameter int PREG_W    = 6;
  parameter int DATA_W    = 32;

  // Tags index the reorder buffer, so the ROB holds at most 16 entries
  parameter int TAG_W     = 4;

  // ==========================================================================
  // Index and data types
  // ==========================================================================
  typedef logic [AREG_W-1:0] areg_t;
  typedef logic [PREG_W-1:0] preg_t;
  typedef logic [TAG_W-1:0]  rob_tag_t;
  typedef logic [DATA_W-1:0] data_t;

endpackage
